// ==== verilog/sf_video_pkg.sv ====
// character video shared definitions

package sf_video_pkg;

   // ==================================================
   // sizes
   // ==================================================
   localparam int NUM_LAYERS = 4;
   localparam int LAYER_W    = 2;
   // one bitplane byte is also one character row
   localparam int PLANE_W    = 8;
   localparam int PIX_W      = 2;
   localparam int CIDX_W     = LAYER_W + PIX_W;
   localparam int PAL_DEPTH  = 16;
   // red 3, green 3, blue 2
   localparam int RGB_W      = 8;
   localparam int PIX_DIV    = 8;

   // APB bus
   localparam int ADDR_W     = 8;
   localparam int DATA_W     = 8;

   // register select codes, select 2 is a hole
   localparam logic [1:0] SEL_PLANE0 = 2'd0;
   localparam logic [1:0] SEL_PLANE1 = 2'd1;
   localparam logic [1:0] SEL_CTRL   = 2'd3;

   // ==================================================
   // APB address word, register or palette region
   // ==================================================
   typedef union packed {
      struct packed {
         logic               region;
         logic [2:0]         rsvd;
         logic [LAYER_W-1:0] layer;
         logic [1:0]         sel;
      } regs;
      struct packed {
         logic               region;
         logic [2:0]         rsvd;
         logic [CIDX_W-1:0]  idx;
      } pal;
   } sf_addr_u;

endpackage

// ==== verilog/sf_apb_regs.sv ====
// APB register file for the tile layers

`timescale 1ns/1ps

module sf_apb_regs
(
   input  logic                                                   clk,
   input  logic                                                   CR,
   input  logic                                                   psel_i,
   input  logic                                                   penable_i,
   input  logic                                                   pwrite_i,
   input  logic [sf_video_pkg::ADDR_W-1:0]                        paddr_i,
   input  logic [sf_video_pkg::DATA_W-1:0]                        pwdata_i,
   output logic [sf_video_pkg::DATA_W-1:0]                        prdata_o,
   output logic [sf_video_pkg::NUM_LAYERS-1:0][sf_video_pkg::PLANE_W-1:0] plane0_o,
   output logic [sf_video_pkg::NUM_LAYERS-1:0][sf_video_pkg::PLANE_W-1:0] plane1_o,
   output logic [sf_video_pkg::NUM_LAYERS-1:0]                    layer_en_o,
   output logic                                                   pal_we_o,
   output logic [sf_video_pkg::CIDX_W-1:0]                        pal_waddr_o,
   output logic [sf_video_pkg::RGB_W-1:0]                         pal_wdata_o
);
   import sf_video_pkg::*;

   sf_addr_u                                addr;
   logic                                    wr_en;
   logic                                    rd_setup;
   logic [DATA_W-1:0]                       rd_data;
   logic [NUM_LAYERS-1:0][PLANE_W-1:0]      plane0_q;
   logic [NUM_LAYERS-1:0][PLANE_W-1:0]      plane1_q;
   logic [NUM_LAYERS-1:0]                   layer_en_q;

   assign addr     = paddr_i;
   // zero wait states, write lands at the end of the access cycle
   assign wr_en    = psel_i & penable_i & pwrite_i;
   assign rd_setup = psel_i & ~penable_i & ~pwrite_i;

   // ==================================================
   // staging bytes and layer enable
   // ==================================================
   always_ff @(posedge clk or negedge CR)
   begin
      if (!CR)
      begin
         plane0_q   <= '0;
         plane1_q   <= '0;
         layer_en_q <= '0;
      end
      else if (wr_en && !addr.regs.region)
      begin
         case (addr.regs.sel)
            SEL_PLANE0: plane0_q[addr.regs.layer] <= pwdata_i;
            SEL_PLANE1: plane1_q[addr.regs.layer] <= pwdata_i;
            SEL_CTRL:
            begin
               // control lives at layer 0 only
               if (addr.regs.layer == '0)
                  layer_en_q <= pwdata_i[NUM_LAYERS-1:0];
            end
            default: ;
         endcase
      end
   end

   // read mux, palette region reads zero
   always_comb
   begin
      rd_data = '0;
      if (!addr.regs.region)
      begin
         case (addr.regs.sel)
            SEL_PLANE0: rd_data = plane0_q[addr.regs.layer];
            SEL_PLANE1: rd_data = plane1_q[addr.regs.layer];
            SEL_CTRL:
            begin
               if (addr.regs.layer == '0)
                  rd_data = DATA_W'(layer_en_q);
            end
            default: rd_data = '0;
         endcase
      end
   end

   // sampled in setup, held through the access cycle
   always_ff @(posedge clk or negedge CR)
   begin
      if (!CR)
         prdata_o <= '0;
      else if (rd_setup)
         prdata_o <= rd_data;
   end

   // palette writes go straight through to the RAM
   assign pal_we_o    = wr_en & addr.pal.region;
   assign pal_waddr_o = addr.pal.idx;
   assign pal_wdata_o = pwdata_i;

   assign plane0_o   = plane0_q;
   assign plane1_o   = plane1_q;
   assign layer_en_o = layer_en_q;

endmodule

// ==== verilog/sf_pixel_timer.sv ====
// pixel enable and character reload

`timescale 1ns/1ps

module sf_pixel_timer
(
   input  logic clk,
   input  logic CR,
   output logic pix_cen_o,
   output logic reload_o
);
   import sf_video_pkg::*;

   logic [$clog2(PIX_DIV)-1:0] div_q;
   logic [$clog2(PLANE_W)-1:0] pos_q;

   // free running divider, enable on the last count
   always_ff @(posedge clk or negedge CR)
   begin
      if (!CR)
         div_q <= '0;
      else
         div_q <= div_q + 1'b1;
   end

   assign pix_cen_o = (div_q == ($clog2(PIX_DIV))'(PIX_DIV - 1));

   // pixel position inside the character
   always_ff @(posedge clk or negedge CR)
   begin
      if (!CR)
         pos_q <= '0;
      else if (pix_cen_o)
         pos_q <= pos_q + 1'b1;
   end

   assign reload_o = pix_cen_o && (pos_q == ($clog2(PLANE_W))'(PLANE_W - 1));

endmodule

// ==== verilog/sf_plane_shifter.sv ====
// bitplane shift register pair

`timescale 1ns/1ps

module sf_plane_shifter
(
   input  logic                             clk,
   input  logic                             CR,
   input  logic                             pix_cen_i,
   input  logic                             reload_i,
   input  logic [sf_video_pkg::PLANE_W-1:0] plane0_i,
   input  logic [sf_video_pkg::PLANE_W-1:0] plane1_i,
   output logic [sf_video_pkg::PIX_W-1:0]   pix_o
);
   import sf_video_pkg::*;

   logic [PLANE_W-1:0] sh0_q;
   logic [PLANE_W-1:0] sh1_q;

   // load at the character edge, else shift left
   always_ff @(posedge clk or negedge CR)
   begin
      if (!CR)
      begin
         sh0_q <= '0;
         sh1_q <= '0;
      end
      else if (pix_cen_i)
      begin
         if (reload_i)
         begin
            sh0_q <= plane0_i;
            sh1_q <= plane1_i;
         end
         else
         begin
            sh0_q <= {sh0_q[PLANE_W-2:0], 1'b0};
            sh1_q <= {sh1_q[PLANE_W-2:0], 1'b0};
         end
      end
   end

   // plane 1 is the upper pixel bit
   assign pix_o = {sh1_q[PLANE_W-1], sh0_q[PLANE_W-1]};

endmodule

// ==== verilog/sf_priority_mixer.sv ====
// fixed priority layer mixer

`timescale 1ns/1ps

module sf_priority_mixer
(
   input  logic                                                      clk,
   input  logic                                                      CR,
   input  logic                                                      pix_cen_i,
   input  logic [sf_video_pkg::NUM_LAYERS-1:0][sf_video_pkg::PIX_W-1:0] layer_pix_i,
   input  logic [sf_video_pkg::NUM_LAYERS-1:0]                       layer_en_i,
   output logic [sf_video_pkg::CIDX_W-1:0]                           cidx_o,
   output logic                                                      cidx_valid_o
);
   import sf_video_pkg::*;

   logic [CIDX_W-1:0] win_idx;
   logic              found;

   // lowest enabled opaque layer wins, pixel 0 is transparent
   always_comb
   begin
      win_idx = '0;
      found   = 1'b0;
      for (int i = 0; i < NUM_LAYERS; i++)
      begin
         if (!found && layer_en_i[i] && (layer_pix_i[i] != '0))
         begin
            found   = 1'b1;
            win_idx = {LAYER_W'(i), layer_pix_i[i]};
         end
      end
   end

   always_ff @(posedge clk or negedge CR)
   begin
      if (!CR)
      begin
         cidx_o       <= '0;
         cidx_valid_o <= 1'b0;
      end
      else
      begin
         cidx_valid_o <= pix_cen_i;
         if (pix_cen_i)
            cidx_o <= win_idx;
      end
   end

endmodule

// ==== verilog/sf_palette_out.sv ====
// palette RAM and RGB pixel output

`timescale 1ns/1ps

module sf_palette_out
(
   input  logic                            clk,
   input  logic                            CR,
   input  logic                            pal_we_i,
   input  logic [sf_video_pkg::CIDX_W-1:0] pal_waddr_i,
   input  logic [sf_video_pkg::RGB_W-1:0]  pal_wdata_i,
   input  logic [sf_video_pkg::CIDX_W-1:0] cidx_i,
   input  logic                            cidx_valid_i,
   output logic [sf_video_pkg::RGB_W-1:0]  pixel_o,
   output logic                            pixel_valid_o
);
   import sf_video_pkg::*;

   logic [RGB_W-1:0] pal_mem [PAL_DEPTH];

   // ==================================================
   // palette storage, cleared by reset
   // ==================================================
   always_ff @(posedge clk or negedge CR)
   begin
      if (!CR)
      begin
         for (int i = 0; i < PAL_DEPTH; i++)
            pal_mem[i] <= '0;
      end
      else if (pal_we_i)
         pal_mem[pal_waddr_i] <= pal_wdata_i;
   end

   // lookup, {r[2:0], g[2:0], b[1:0]}
   always_ff @(posedge clk or negedge CR)
   begin
      if (!CR)
      begin
         pixel_o       <= '0;
         pixel_valid_o <= 1'b0;
      end
      else
      begin
         pixel_valid_o <= cidx_valid_i;
         if (cidx_valid_i)
            pixel_o <= pal_mem[cidx_i];
      end
   end

endmodule

// ==== verilog/sf_video_core.sv ====
// character video core top level

`timescale 1ns/1ps

module sf_video_core
(
   input  logic                            clk,
   input  logic                            CR,
   input  logic                            psel_i,
   input  logic                            penable_i,
   input  logic                            pwrite_i,
   input  logic [sf_video_pkg::ADDR_W-1:0] paddr_i,
   input  logic [sf_video_pkg::DATA_W-1:0] pwdata_i,
   output logic [sf_video_pkg::DATA_W-1:0] prdata_o,
   output logic [sf_video_pkg::RGB_W-1:0]  pixel_o,
   output logic                            pixel_valid_o
);
   import sf_video_pkg::*;

   logic [NUM_LAYERS-1:0][PLANE_W-1:0] plane0_q;
   logic [NUM_LAYERS-1:0][PLANE_W-1:0] plane1_q;
   logic [NUM_LAYERS-1:0]              layer_en_q;
   logic                               pal_we;
   logic [CIDX_W-1:0]                  pal_waddr;
   logic [RGB_W-1:0]                   pal_wdata;
   logic                               pix_cen;
   logic                               reload;
   logic [NUM_LAYERS-1:0][PIX_W-1:0]   pix;
   logic [CIDX_W-1:0]                  cidx;
   logic                               cidx_valid;

   sf_apb_regs u_apb_regs (
      .clk         (clk),
      .CR          (CR),
      .psel_i      (psel_i),
      .penable_i   (penable_i),
      .pwrite_i    (pwrite_i),
      .paddr_i     (paddr_i),
      .pwdata_i    (pwdata_i),
      .prdata_o    (prdata_o),
      .plane0_o    (plane0_q),
      .plane1_o    (plane1_q),
      .layer_en_o  (layer_en_q),
      .pal_we_o    (pal_we),
      .pal_waddr_o (pal_waddr),
      .pal_wdata_o (pal_wdata)
   );

   sf_pixel_timer u_pixel_timer (
      .clk       (clk),
      .CR        (CR),
      .pix_cen_o (pix_cen),
      .reload_o  (reload)
   );

   // ==================================================
   // one shifter pair per layer
   // ==================================================
   for (genvar g = 0; g < NUM_LAYERS; g++)
   begin : g_layer
      sf_plane_shifter u_plane_shifter (
         .clk       (clk),
         .CR        (CR),
         .pix_cen_i (pix_cen),
         .reload_i  (reload),
         .plane0_i  (plane0_q[g]),
         .plane1_i  (plane1_q[g]),
         .pix_o     (pix[g])
      );
   end

   sf_priority_mixer u_priority_mixer (
      .clk          (clk),
      .CR           (CR),
      .pix_cen_i    (pix_cen),
      .layer_pix_i  (pix),
      .layer_en_i   (layer_en_q),
      .cidx_o       (cidx),
      .cidx_valid_o (cidx_valid)
   );

   sf_palette_out u_palette_out (
      .clk           (clk),
      .CR            (CR),
      .pal_we_i      (pal_we),
      .pal_waddr_i   (pal_waddr),
      .pal_wdata_i   (pal_wdata),
      .cidx_i        (cidx),
      .cidx_valid_i  (cidx_valid),
      .pixel_o       (pixel_o),
      .pixel_valid_o (pixel_valid_o)
   );

endmodule

// ==== test/tb_sf_video_core.sv ====
// character video core testbench

`timescale 1ns/1ps

module tb_sf_video_core;
   import sf_video_pkg::*;

   localparam logic [31:0] SEED = 32'hc041_2bcd;
   localparam int CLK_NS       = 4;
   localparam int RESET_CYCLES = 10;
   localparam int NUM_WINDOWS  = 34;
   // two leading characters carry no written data
   localparam int NUM_CHARS    = NUM_WINDOWS + 2;
   localparam int CHAR_CLKS    = PIX_DIV * PLANE_W;
   // first pix_cen in cycle 8, then mixer and palette stages
   localparam int FIRST_VALID  = PIX_DIV + 2;
   localparam int TIMEOUT_NS   = NUM_CHARS * CHAR_CLKS * CLK_NS + 2000;

   logic               clk;
   logic               CR;
   logic               psel;
   logic               penable;
   logic               pwrite;
   logic [ADDR_W-1:0]  paddr;
   logic [DATA_W-1:0]  pwdata;
   logic [DATA_W-1:0]  prdata;
   logic [RGB_W-1:0]   pixel;
   logic               pixel_valid;

   // ==================================================
   // reference model state
   // ==================================================
   logic [31:0]                        lfsr_q;
   logic [NUM_LAYERS-1:0][PLANE_W-1:0] m_plane0 = '0;
   logic [NUM_LAYERS-1:0][PLANE_W-1:0] m_plane1 = '0;
   logic [NUM_LAYERS-1:0][PLANE_W-1:0] cur_plane0 = '0;
   logic [NUM_LAYERS-1:0][PLANE_W-1:0] cur_plane1 = '0;
   logic [NUM_LAYERS-1:0]              m_en = '0;
   logic [NUM_LAYERS-1:0]              en_d1 = '0;
   logic [NUM_LAYERS-1:0]              en_d2 = '0;
   logic [NUM_LAYERS-1:0]              en_d3 = '0;
   logic [PAL_DEPTH-1:0][RGB_W-1:0]    m_pal = '0;
   logic [PAL_DEPTH-1:0][RGB_W-1:0]    pal_d1 = '0;
   logic [PAL_DEPTH-1:0][RGB_W-1:0]    pal_d2 = '0;
   // staged bytes per character, tagged with the character number
   logic [NUM_LAYERS-1:0][PLANE_W-1:0] snap0_q [$];
   logic [NUM_LAYERS-1:0][PLANE_W-1:0] snap1_q [$];
   int                                 tag_q [$];
   int pix_cnt    = 0;
   int chars_seen = 0;
   int cyc_cnt    = 0;
   int pix_pos    = 0;
   int char_idx   = 0;
   int pixel_errs = 0;
   int read_errs  = 0;
   int proto_errs = 0;

   sf_video_core u_sf_video_core (
      .clk           (clk),
      .CR            (CR),
      .psel_i        (psel),
      .penable_i     (penable),
      .pwrite_i      (pwrite),
      .paddr_i       (paddr),
      .pwdata_i      (pwdata),
      .prdata_o      (prdata),
      .pixel_o       (pixel),
      .pixel_valid_o (pixel_valid)
   );

   initial clk = 1'b0;
   always #(CLK_NS / 2) clk = ~clk;

   // x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic draw_bits(input int n, output logic [31:0] val);
      val = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr_q = lfsr_step(lfsr_q);
         val    = {val[30:0], lfsr_q[0]};
      end
   endtask

   function automatic logic [ADDR_W-1:0] reg_addr(input logic [LAYER_W-1:0] layer,
                                                  input logic [1:0] sel);
      sf_addr_u a;
      a           = '0;
      a.regs.layer = layer;
      a.regs.sel   = sel;
      return a;
   endfunction

   function automatic logic [ADDR_W-1:0] pal_addr(input logic [CIDX_W-1:0] idx);
      sf_addr_u a;
      a             = '0;
      a.pal.region  = 1'b1;
      a.pal.idx     = idx;
      return a;
   endfunction

   // select 2 anywhere, or control select off layer 0
   function automatic logic [ADDR_W-1:0] ignored_addr(input logic [2:0] r);
      logic [LAYER_W-1:0] layer;
      layer = r[LAYER_W-1:0];
      if (r[2])
         return reg_addr(layer, 2'd2);
      if (layer == '0)
         layer = LAYER_W'(1);
      return reg_addr(layer, SEL_CTRL);
   endfunction

   // lowest enabled opaque layer, pixel bits taken MSB first
   function automatic logic [RGB_W-1:0] expected_rgb(
      input int                                 pos,
      input logic [NUM_LAYERS-1:0][PLANE_W-1:0] p0,
      input logic [NUM_LAYERS-1:0][PLANE_W-1:0] p1,
      input logic [NUM_LAYERS-1:0]              en,
      input logic [PAL_DEPTH-1:0][RGB_W-1:0]    pal);
      logic [PIX_W-1:0]  pix;
      logic [CIDX_W-1:0] idx;
      logic              hit;
      idx = '0;
      hit = 1'b0;
      for (int l = 0; l < NUM_LAYERS; l++)
      begin
         pix = {p1[l][PLANE_W-1-pos], p0[l][PLANE_W-1-pos]};
         if (!hit && en[l] && pix != '0)
         begin
            hit = 1'b1;
            idx = {LAYER_W'(l), pix};
         end
      end
      return pal[idx];
   endfunction

   task automatic check_pixel(input logic [RGB_W-1:0] got, input logic [RGB_W-1:0] exp,
                              input int n);
      if (got !== exp)
      begin
         pixel_errs++;
         $display("[FAIL] %0t pixel %0d: got %h, expected %h", $time, n, got, exp);
      end
   endtask

   task automatic check_read(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                             input logic [ADDR_W-1:0] addr);
      if (got !== exp)
      begin
         read_errs++;
         $display("[FAIL] %0t read of %h: got %h, expected %h", $time, addr, got, exp);
      end
   endtask

   // ==================================================
   // APB master, zero wait states
   // ==================================================
   task automatic apb_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
      @(posedge clk);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= 1'b1;
      paddr   <= addr;
      pwdata  <= data;
      @(posedge clk);
      penable <= 1'b1;
      @(posedge clk);
      psel    <= 1'b0;
      penable <= 1'b0;
      pwrite  <= 1'b0;
   endtask

   task automatic apb_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
      @(posedge clk);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= 1'b0;
      paddr   <= addr;
      @(posedge clk);
      penable <= 1'b1;
      @(posedge clk);
      data = prdata;
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   // one character window, staging data lands before the next reload
   task automatic run_window(input int tgt);
      logic [31:0]           r;
      logic [NUM_LAYERS-1:0] mask;
      logic [DATA_W-1:0]     got;
      logic [ADDR_W-1:0]     addr;
      logic [CIDX_W-1:0]     idx;
      for (int l = 0; l < NUM_LAYERS; l++)
      begin
         draw_bits(2 * PLANE_W, r);
         apb_write(reg_addr(LAYER_W'(l), SEL_PLANE0), r[PLANE_W-1:0]);
         m_plane0[l] = r[PLANE_W-1:0];
         apb_write(reg_addr(LAYER_W'(l), SEL_PLANE1), r[2*PLANE_W-1:PLANE_W]);
         m_plane1[l] = r[2*PLANE_W-1:PLANE_W];
      end
      // layer 0 alone, then all layers, then random masks
      if (tgt < 12)
         mask = NUM_LAYERS'(1);
      else if (tgt < 24)
         mask = '1;
      else
      begin
         draw_bits(NUM_LAYERS, r);
         mask = r[NUM_LAYERS-1:0];
      end
      apb_write(reg_addr('0, SEL_CTRL), DATA_W'(mask));
      m_en = mask;
      snap0_q.push_back(m_plane0);
      snap1_q.push_back(m_plane1);
      tag_q.push_back(tgt);

      draw_bits(3 + DATA_W, r);
      apb_write(ignored_addr(r[2:0]), r[DATA_W+2:3]);
      if (tgt >= 8)
      begin
         draw_bits(CIDX_W + RGB_W, r);
         idx = r[CIDX_W-1:0];
         apb_write(pal_addr(idx), r[CIDX_W+RGB_W-1:CIDX_W]);
         m_pal[idx] = r[CIDX_W+RGB_W-1:CIDX_W];
      end

      // readback
      draw_bits(3, r);
      addr = reg_addr(r[LAYER_W-1:0], r[2] ? SEL_PLANE1 : SEL_PLANE0);
      apb_read(addr, got);
      check_read(got, r[2] ? m_plane1[r[LAYER_W-1:0]] : m_plane0[r[LAYER_W-1:0]], addr);
      addr = reg_addr('0, SEL_CTRL);
      apb_read(addr, got);
      check_read(got, DATA_W'(m_en), addr);
      draw_bits(CIDX_W + 1, r);
      addr = r[CIDX_W] ? pal_addr(r[CIDX_W-1:0]) : ignored_addr(r[2:0]);
      apb_read(addr, got);
      check_read(got, '0, addr);
   endtask

   // model history, taken between rising edges
   always @(negedge clk)
   begin
      en_d3  = en_d2;
      en_d2  = en_d1;
      en_d1  = m_en;
      pal_d2 = pal_d1;
      pal_d1 = m_pal;
   end

   // ==================================================
   // pixel monitor
   // ==================================================
   always @(posedge clk)
   begin
      if (!CR)
      begin
         if (pixel_valid)
         begin
            proto_errs++;
            $display("pixel_valid_o was high during reset at %0t", $time);
         end
         if (pixel !== '0)
         begin
            proto_errs++;
            $display("pixel_o was not zero during reset at %0t", $time);
         end
      end
      else
      begin
         cyc_cnt++;
         if (pixel_valid)
         begin
            if (cyc_cnt != FIRST_VALID + PIX_DIV * pix_cnt)
            begin
               proto_errs++;
               $display("pixel %0d arrived in cycle %0d after reset, not in cycle %0d",
                        pix_cnt, cyc_cnt, FIRST_VALID + PIX_DIV * pix_cnt);
            end
            pix_pos = pix_cnt % PLANE_W;
            if (pix_pos == 0)
            begin
               char_idx = pix_cnt / PLANE_W;
               if (tag_q.size() != 0 && tag_q[0] == char_idx)
               begin
                  cur_plane0 = snap0_q.pop_front();
                  cur_plane1 = snap1_q.pop_front();
                  void'(tag_q.pop_front());
               end
               chars_seen = char_idx + 1;
            end
            check_pixel(pixel, expected_rgb(pix_pos, cur_plane0, cur_plane1, en_d3, pal_d2),
                        pix_cnt);
            pix_cnt++;
         end
      end
   end

   initial
   begin
      #(TIMEOUT_NS);
      $display("watchdog expired after %0d ns, the pixel stream or the bus hung", TIMEOUT_NS);
      $display("TEST RESULT: FAIL");
      $finish;
   end

   // ==================================================
   // main sequence
   // ==================================================
   initial
   begin
      logic [31:0] r;
      int          next_char;
      $timeformat(-9, 0, " ns", 0);
      lfsr_q = SEED;
      CR      <= 1'b0;
      psel    <= 1'b0;
      penable <= 1'b0;
      pwrite  <= 1'b0;
      paddr   <= '0;
      pwdata  <= '0;
      repeat (RESET_CYCLES) @(posedge clk);
      CR <= 1'b1;

      // fill the whole palette
      for (int i = 0; i < PAL_DEPTH; i++)
      begin
         draw_bits(RGB_W, r);
         apb_write(pal_addr(CIDX_W'(i)), r[RGB_W-1:0]);
         m_pal[i] = r[RGB_W-1:0];
      end

      next_char = chars_seen;
      for (int w = 0; w < NUM_WINDOWS; w++)
      begin
         wait (chars_seen > next_char);
         if (chars_seen != next_char + 1)
         begin
            proto_errs++;
            $display("bus writes fell behind the pixel stream at character %0d", chars_seen);
         end
         next_char = chars_seen;
         run_window(chars_seen);
      end

      wait (pix_cnt >= NUM_CHARS * PLANE_W);
      @(posedge clk);
      $display("errors: pixel %0d, read %0d, protocol %0d, pixels checked %0d",
               pixel_errs, read_errs, proto_errs, pix_cnt);
      if (pixel_errs + read_errs + proto_errs == 0)
         $display("TEST RESULT: PASS");
      else
         $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

// ==== flist.f ====
verilog/sf_video_pkg.sv
verilog/sf_apb_regs.sv
verilog/sf_pixel_timer.sv
verilog/sf_plane_shifter.sv
verilog/sf_priority_mixer.sv
verilog/sf_palette_out.sv
verilog/sf_video_core.sv
test/tb_sf_video_core.sv

// ==== Makefile ====
# Verilator build and run for the character video core

VERILATOR ?= verilator
TOP       ?= tb_sf_video_core
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -Wno-fatal

.PHONY: help build test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

test: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG) || (echo "no result line in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
